/* common/tx_link_pkg.sv */
/*
  tx link constants
  frame geometry, loop and pad tables per channel count, sync codes,
  transmit FIFO sizing and key debounce timing
*/

package tx_link_pkg;

  //////////////////////////////////////////////////////////////////////////
  // frame geometry
  localparam int HDR_WORDS     = 4;                        // sync + c&c words
  localparam int PAYLOAD_WORDS = 252;                      // samples + pad
  localparam int FRAME_WORDS   = HDR_WORDS + PAYLOAD_WORDS; // 256 words
  localparam int MAX_CHAN      = 7;                        // highest channel index
  localparam int CHAN_W        = 3;

  // loops = 252 / (3*(last_chan+1)+1), pad = 252 - loops*loop_len
  localparam logic [6:0] LOOP_TABLE [0:MAX_CHAN] =
    '{7'd63, 7'd36, 7'd25, 7'd19, 7'd15, 7'd13, 7'd11, 7'd10};
  localparam logic [5:0] PAD_TABLE [0:MAX_CHAN] =
    '{6'd0, 6'd0, 6'd2, 6'd5, 6'd12, 6'd5, 6'd10, 6'd2};

  //////////////////////////////////////////////////////////////////////////
  // header codes
  localparam logic [15:0] SYNC_WORD = 16'h7F7F;
  localparam logic [7:0]  SYNC_BYTE = 8'h7F;
  localparam int          ADDR_W    = 5;
  localparam logic [ADDR_W-1:0] MAX_ADDR = 5'd1;            // round robin wraps here

  //////////////////////////////////////////////////////////////////////////
  // transmit FIFO
  localparam int FIFO_DEPTH = 1024;
  localparam int FIFO_AW    = 11;                          // holds 0..FIFO_DEPTH
  localparam logic [FIFO_AW-1:0] FIFO_FULL  = FIFO_AW'(FIFO_DEPTH);
  localparam logic [FIFO_AW-1:0] ROOM_LIMIT = FIFO_AW'(FIFO_DEPTH - FRAME_WORDS);

  // start delay and key debounce
  localparam int START_DELAY = 32;                         // idle cycles
  localparam int DELAY_W     = 6;
  localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(START_DELAY - 1);
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DB_W            = 5;
  localparam logic [DB_W-1:0] DB_LAST = DB_W'(DEBOUNCE_CYCLES - 1);

endpackage

/* source/key_debounce.sv */
/*
  key debouncer
  two-flop synchronizer and stability counter per key input
*/

`timescale 1ns/1ps

module key_debounce
(
  input  logic IF_clk,
  input  logic IF_reset,
  input  logic key_dot,
  input  logic key_dash,
  input  logic key_ptt,
  output logic clean_dot,
  output logic clean_dash,
  output logic clean_ptt
);

  logic [2:0] raw;                           // ptt, dash, dot
  logic [2:0] sync_a;
  logic [2:0] sync_b;
  logic [2:0] clean;
  logic [4:0] db_cnt [0:2];                  // stable cycles per key

  assign raw        = {key_ptt, key_dash, key_dot};
  assign clean_dot  = clean[0];
  assign clean_dash = clean[1];
  assign clean_ptt  = clean[2];

  always_ff @(posedge IF_clk)
  begin
    if (IF_reset)
    begin
      sync_a <= '0;
      sync_b <= '0;
      clean  <= '0;
      for (int k = 0; k < 3; k++)
        db_cnt[k] <= '0;
    end
    else
    begin
      sync_a <= raw;
      sync_b <= sync_a;
      for (int k = 0; k < 3; k++)
      begin
        if (sync_b[k] == clean[k])
          db_cnt[k] <= '0;                   // no change pending
        else if (db_cnt[k] == tx_link_pkg::DB_LAST)
        begin
          clean[k]  <= sync_b[k];            // held long enough, take it
          db_cnt[k] <= '0;
        end
        else
          db_cnt[k] <= db_cnt[k] + 5'd1;
      end
    end
  end

endmodule

/* source/iq_mic_gather.sv */
/*
  iq/mic gather bank
  collects one iq beat per channel plus the channel 0 mic sample,
  then holds the set for the framer until it is acknowledged
*/

`timescale 1ns/1ps

module iq_mic_gather
(
  input  logic        IF_clk,
  input  logic        IF_reset,
  input  logic        sample_valid,
  input  logic [47:0] sample_iq,
  input  logic [15:0] sample_mic,
  input  logic [2:0]  last_chan,
  input  logic [2:0]  rd_chan,
  input  logic        set_ack,
  output logic        sample_ready,
  output logic        set_rdy,
  output logic [63:0] set_data
);

  logic [47:0] iq_bank [0:tx_link_pkg::MAX_CHAN];  // one entry per channel
  logic [15:0] mic_reg;                            // mic of channel 0 beat
  logic [2:0]  wr_idx;                             // next channel to store
  logic        beat;

  assign beat     = sample_valid && sample_ready;
  assign set_data = {iq_bank[rd_chan], mic_reg};

  ////////////////////////////////////////////////////////////////////////////
  // sample payload
  always_ff @(posedge IF_clk)
  begin
    if (beat)
      iq_bank[wr_idx] <= sample_iq;
    if (beat && (wr_idx == 3'd0))
      mic_reg <= sample_mic;
  end

  ////////////////////////////////////////////////////////////////////////////
  // set handshake with the framer
  always_ff @(posedge IF_clk)
  begin
    if (IF_reset)
    begin
      set_rdy      <= 1'b0;
      sample_ready <= 1'b0;                  // opens one cycle after reset
      wr_idx       <= '0;
    end
    else if (set_rdy)
    begin
      if (set_ack)                           // framer done with the set
      begin
        set_rdy      <= 1'b0;
        sample_ready <= 1'b1;
        wr_idx       <= '0;
      end
    end
    else if (beat)
    begin
      if (wr_idx == last_chan)               // set complete
      begin
        set_rdy      <= 1'b1;
        sample_ready <= 1'b0;
      end
      else
        wr_idx <= wr_idx + 3'd1;
    end
    else
      sample_ready <= 1'b1;
  end

endmodule

/* tx_frame/tx_word_fifo.sv */
/*
  tx word FIFO
  16-bit synchronous circular FIFO with clear, fill count and
  a valid/ready read port
*/

`timescale 1ns/1ps

module tx_word_fifo
(
  input  logic        IF_clk,
  input  logic        IF_reset,
  input  logic [15:0] wdata,
  input  logic        wreq,
  input  logic        clr,
  input  logic        out_ready,
  output logic [10:0] used,
  output logic        out_valid,
  output logic [15:0] out_data
);

  logic [15:0] mem [0:tx_link_pkg::FIFO_DEPTH-1];
  logic [9:0]  wr_ptr;
  logic [9:0]  rd_ptr;
  logic        do_wr;
  logic        do_rd;

  assign do_wr     = wreq && (used != tx_link_pkg::FIFO_FULL);  // drop when full
  assign do_rd     = out_valid && out_ready;
  assign out_valid = (used != '0);
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge IF_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge IF_clk)
  begin
    if (IF_reset || clr)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 10'd1;            // wraps at depth
      if (do_rd)
        rd_ptr <= rd_ptr + 10'd1;
      case ({do_wr, do_rd})
        2'b10:   used <= used + 11'd1;
        2'b01:   used <= used - 11'd1;
        default: used <= used;               // none, or both at once
      endcase
    end
  end

endmodule

/* tx_frame/tx_frame_ctrl.sv */
/*
  tx frame controller
  writes sync, round-robin c&c, sample loops and zero pad into the tx FIFO,
  clears the FIFO and restarts when a frame no longer fits
*/

`timescale 1ns/1ps

module tx_frame_ctrl
(
  input  logic        IF_clk,
  input  logic        IF_reset,
  input  logic [10:0] fifo_used,
  input  logic        set_rdy,
  input  logic [63:0] set_data,
  input  logic [2:0]  last_chan,
  input  logic        clean_dot,
  input  logic        clean_dash,
  input  logic        clean_ptt,
  input  logic        adc_overload,
  input  logic [7:0]  merc_serial,
  input  logic [7:0]  penny_serial,
  input  logic [7:0]  ozy_serial,
  input  logic [11:0] penny_alc,
  output logic [15:0] fifo_wdata,
  output logic        fifo_wreq,
  output logic        fifo_clr,
  output logic        set_ack,
  output logic [2:0]  rd_chan
);

  typedef enum logic [3:0]
  {
    ST_IDLE,
    ST_SYNC1,
    ST_SYNC2,
    ST_CTL12,
    ST_CTL34,
    ST_WAIT_SET,
    ST_IQ1,
    ST_IQ2,
    ST_IQ3,
    ST_MIC,
    ST_ACK_WAIT,
    ST_LOOP_CHK,
    ST_PAD,
    ST_ERR
  } frame_state_t;

  frame_state_t state;
  frame_state_t state_next;

  logic [5:0]  delay_cnt;                    // start delay timer
  logic [4:0]  tx_addr;                      // round robin c&c address
  logic [6:0]  loop_cnt;                     // completed sample loops
  logic [5:0]  pad_cnt;                      // pad words written
  logic [6:0]  loop_num;
  logic [5:0]  pad_num;
  logic [15:0] c12_word;                     // c1,c2 of current address
  logic [15:0] c34_word;                     // c3,c4 of current address

  assign loop_num = tx_link_pkg::LOOP_TABLE[last_chan];
  assign pad_num  = tx_link_pkg::PAD_TABLE[last_chan];

  assign set_ack  = (state == ST_ACK_WAIT);  // held till set_rdy drops
  assign fifo_clr = (state == ST_ERR);       // single cycle, err always leaves

  ////////////////////////////////////////////////////////////////////////////
  // c&c payload per address
  always_comb
  begin
    case (tx_addr)
      5'd0:
      begin
        c12_word = {7'd0, adc_overload, merc_serial};
        c34_word = {penny_serial, ozy_serial};
      end
      5'd1:
      begin
        c12_word = {4'd0, penny_alc};        // alc upper nibble, then low byte
        c34_word = 16'd0;                    // alex reverse power, unused
      end
      default:
      begin
        c12_word = 16'd0;
        c34_word = 16'd0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // counters and state register
  always_ff @(posedge IF_clk)
  begin
    if (IF_reset)
      state <= ST_IDLE;
    else
      state <= state_next;

    if (IF_reset || (state != ST_IDLE))
      delay_cnt <= '0;                       // restarts on each idle entry
    else
      delay_cnt <= delay_cnt + 6'd1;

    if (IF_reset)
      tx_addr <= '0;
    else if (state == ST_CTL34)              // advance once per frame
    begin
      if (tx_addr == tx_link_pkg::MAX_ADDR)
        tx_addr <= '0;
      else
        tx_addr <= tx_addr + 5'd1;
    end

    if (IF_reset || (state == ST_SYNC1))
      loop_cnt <= '0;
    else if (state == ST_LOOP_CHK)
      loop_cnt <= loop_cnt + 7'd1;

    if (IF_reset || (state == ST_SYNC1))
      pad_cnt <= '0;
    else if (state == ST_PAD)
      pad_cnt <= pad_cnt + 6'd1;

    if (IF_reset || (state == ST_WAIT_SET))
      rd_chan <= '0;
    else if ((state == ST_IQ3) && (rd_chan != last_chan))
      rd_chan <= rd_chan + 3'd1;             // next channel of the set
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and FIFO write
  always_comb
  begin
    state_next = state;
    fifo_wdata = 16'd0;
    fifo_wreq  = 1'b0;
    case (state)
      ST_IDLE:
      begin
        if (delay_cnt == tx_link_pkg::DELAY_LAST)
          state_next = ST_SYNC1;
      end

      ST_SYNC1:
      begin
        if (fifo_used > tx_link_pkg::ROOM_LIMIT)
          state_next = ST_ERR;               // no room for a whole frame
        else
        begin
          fifo_wdata = tx_link_pkg::SYNC_WORD;
          fifo_wreq  = 1'b1;
          state_next = ST_SYNC2;
        end
      end

      ST_SYNC2:
      begin
        fifo_wdata = {tx_link_pkg::SYNC_BYTE, tx_addr, clean_dot, clean_dash, clean_ptt};
        fifo_wreq  = 1'b1;
        state_next = ST_CTL12;
      end

      ST_CTL12:
      begin
        fifo_wdata = c12_word;
        fifo_wreq  = 1'b1;
        state_next = ST_CTL34;
      end

      ST_CTL34:
      begin
        fifo_wdata = c34_word;
        fifo_wreq  = 1'b1;
        state_next = ST_WAIT_SET;
      end

      ST_WAIT_SET:
      begin
        if (set_rdy)                         // sample set gathered
          state_next = ST_IQ1;
      end

      ST_IQ1:
      begin
        fifo_wdata = set_data[63:48];
        fifo_wreq  = 1'b1;
        state_next = ST_IQ2;
      end

      ST_IQ2:
      begin
        fifo_wdata = set_data[47:32];
        fifo_wreq  = 1'b1;
        state_next = ST_IQ3;
      end

      ST_IQ3:
      begin
        fifo_wdata = set_data[31:16];
        fifo_wreq  = 1'b1;
        if (rd_chan != last_chan)
          state_next = ST_IQ1;
        else
          state_next = ST_MIC;
      end

      ST_MIC:
      begin
        fifo_wdata = set_data[15:0];         // one mic word per loop
        fifo_wreq  = 1'b1;
        state_next = ST_ACK_WAIT;
      end

      ST_ACK_WAIT:
      begin
        if (!set_rdy)                        // gather bank released the set
          state_next = ST_LOOP_CHK;
      end

      ST_LOOP_CHK:
      begin
        if (loop_cnt != (loop_num - 7'd1))
          state_next = ST_WAIT_SET;
        else if (pad_num != 6'd0)
          state_next = ST_PAD;
        else
          state_next = ST_SYNC1;
      end

      ST_PAD:
      begin
        fifo_wreq = 1'b1;                    // zero words fill the frame
        if (pad_cnt == (pad_num - 6'd1))
          state_next = ST_SYNC1;
      end

      ST_ERR:
      begin
        state_next = ST_IDLE;                // FIFO cleared this cycle
      end

      default:
      begin
        state_next = ST_IDLE;
      end
    endcase
  end

endmodule

/* source/tx_link_top.sv */
/*
  tx link top
  gather bank, key debouncer, frame controller and tx word FIFO
*/

`timescale 1ns/1ps

module tx_link_top
(
  input  logic        IF_clk,
  input  logic        IF_reset,
  input  logic        sample_valid,
  input  logic [47:0] sample_iq,
  input  logic [15:0] sample_mic,
  input  logic [2:0]  last_chan,
  input  logic        key_dot,
  input  logic        key_dash,
  input  logic        key_ptt,
  input  logic        adc_overload,
  input  logic [7:0]  merc_serial,
  input  logic [7:0]  penny_serial,
  input  logic [7:0]  ozy_serial,
  input  logic [11:0] penny_alc,
  input  logic        out_ready,
  output logic        sample_ready,
  output logic        out_valid,
  output logic [15:0] out_data
);

  logic        set_rdy;                      // gather -> framer
  logic        set_ack;
  logic [2:0]  rd_chan;
  logic [63:0] set_data;
  logic        clean_dot;
  logic        clean_dash;
  logic        clean_ptt;
  logic [15:0] fifo_wdata;                   // framer -> FIFO
  logic        fifo_wreq;
  logic        fifo_clr;
  logic [10:0] fifo_used;

  iq_mic_gather u_gather
  (
    .IF_clk       (IF_clk),
    .IF_reset     (IF_reset),
    .sample_valid (sample_valid),
    .sample_iq    (sample_iq),
    .sample_mic   (sample_mic),
    .last_chan    (last_chan),
    .rd_chan      (rd_chan),
    .set_ack      (set_ack),
    .sample_ready (sample_ready),
    .set_rdy      (set_rdy),
    .set_data     (set_data)
  );

  key_debounce u_debounce
  (
    .IF_clk     (IF_clk),
    .IF_reset   (IF_reset),
    .key_dot    (key_dot),
    .key_dash   (key_dash),
    .key_ptt    (key_ptt),
    .clean_dot  (clean_dot),
    .clean_dash (clean_dash),
    .clean_ptt  (clean_ptt)
  );

  tx_frame_ctrl u_frame
  (
    .IF_clk       (IF_clk),
    .IF_reset     (IF_reset),
    .fifo_used    (fifo_used),
    .set_rdy      (set_rdy),
    .set_data     (set_data),
    .last_chan    (last_chan),
    .clean_dot    (clean_dot),
    .clean_dash   (clean_dash),
    .clean_ptt    (clean_ptt),
    .adc_overload (adc_overload),
    .merc_serial  (merc_serial),
    .penny_serial (penny_serial),
    .ozy_serial   (ozy_serial),
    .penny_alc    (penny_alc),
    .fifo_wdata   (fifo_wdata),
    .fifo_wreq    (fifo_wreq),
    .fifo_clr     (fifo_clr),
    .set_ack      (set_ack),
    .rd_chan      (rd_chan)
  );

  tx_word_fifo u_fifo
  (
    .IF_clk    (IF_clk),
    .IF_reset  (IF_reset),
    .wdata     (fifo_wdata),
    .wreq      (fifo_wreq),
    .clr       (fifo_clr),
    .out_ready (out_ready),
    .used      (fifo_used),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* test/tb_tx_link.sv */
/*
  tx link testbench
  random samples, keys and out_ready from an LCG, frame model with
  sample queue and round-robin address, checked word by word at the output
*/

`timescale 1ns/1ps

module tb_tx_link;

  localparam int STALL    = 16;                      // cycles allowed per word
  localparam int N_FRAMES = 12;                      // frames checked over all runs
  localparam int FILL_CYC = 20000;                   // overflow fill phase
  localparam longint LIMIT_NS = longint'(N_FRAMES * 256 * STALL + FILL_CYC) * 4;

  logic        IF_clk = 1'b0;
  logic        IF_reset;
  logic        sample_valid;
  logic [47:0] sample_iq;
  logic [15:0] sample_mic;
  logic [2:0]  last_chan;
  logic [2:0]  keys;                                 // dot, dash, ptt
  logic        adc_overload;
  logic [7:0]  merc_serial;
  logic [7:0]  penny_serial;
  logic [7:0]  ozy_serial;
  logic [11:0] penny_alc;
  logic        out_ready;
  logic        sample_ready;
  logic        out_valid;
  logic [15:0] out_data;

  logic [31:0] seed = 32'h9be2_7ff1;
  logic [15:0] wq[$];                                // expected sample words
  logic        sq[$];                                // first word of a set
  logic [5:0]  kq[$];                                // key state per written word
  int          key_age[3];
  int          key_hold[3];
  int          ready_mode;                           // 0 high, 1 random, 2 low
  int          lc;
  int          beat_chan;
  int          widx;
  int          frames_done;
  int          clr_count;
  int          n_sample;
  int          exp_addr;
  logic        took;
  logic        pend_chk;
  logic        resync;
  logic        addr_free;
  logic        q_resync;
  logic [15:0] mic_hold;

  tx_link_top UUT
  (
    .IF_clk       (IF_clk),
    .IF_reset     (IF_reset),
    .sample_valid (sample_valid),
    .sample_iq    (sample_iq),
    .sample_mic   (sample_mic),
    .last_chan    (last_chan),
    .key_dot      (keys[2]),
    .key_dash     (keys[1]),
    .key_ptt      (keys[0]),
    .adc_overload (adc_overload),
    .merc_serial  (merc_serial),
    .penny_serial (penny_serial),
    .ozy_serial   (ozy_serial),
    .penny_alc    (penny_alc),
    .out_ready    (out_ready),
    .sample_ready (sample_ready),
    .out_valid    (out_valid),
    .out_data     (out_data)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock and watchdog
  initial
  begin
    forever #2 IF_clk = ~IF_clk;                     // 4 ns period
  end

  initial
  begin
    #(LIMIT_NS);
    $display("Test failed");
    $fatal(1, "timeout: the frames did not arrive within the time limit");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus on the falling edge
  always @(negedge IF_clk)
  begin
    logic [31:0] r;
    logic [63:0] iq;
    if (!sample_valid || took)
    begin
      took = 1'b0;
      r = next_rand();
      sample_valid = (r[19:18] != 2'd0);             // one gap in four
      iq = {next_rand(), next_rand()};
      sample_iq  = iq[47:0];
      r = next_rand();
      sample_mic = r[31:16];
    end
    r = next_rand();
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = (r[21:20] != 2'd0);
      default: out_ready = 1'b0;                     // fill the FIFO
    endcase
    for (int k = 0; k < 3; k++)
    begin
      if (key_hold[k] == 0)
      begin
        r = next_rand();
        key_hold[k] = 40 + int'(r[29:24]);           // at least 40 cycles
        if (keys[k] != r[31])
        begin
          keys[k]    = r[31];
          key_age[k] = 0;
        end
      end
      else
        key_hold[k]--;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output word checker
  task automatic check_word(input logic [15:0] w, input logic [5:0] ki);
    int pos;
    if (resync)
    begin
      if (w != 16'h7F7F)
        return;                                      // leftover words, skip
      resync    = 1'b0;
      addr_free = 1'b1;
      widx      = 0;
    end
    pos = widx - 4;
    if (widx == 0)
      check_value(w, 16'h7F7F, "sync word");
    else if (widx == 1)
    begin
      check_value(w[15:8], 8'h7F, "sync byte");
      if (addr_free)
      begin
        check_value(w[7:3] <= 5'd1, 1, "address in range after resync");
        exp_addr  = w[7:3];
        addr_free = 1'b0;
      end
      check_value(w[7:3], exp_addr, "control address");
      for (int k = 0; k < 3; k++)
        if (ki[k+3])                                 // key stable long enough
          check_value(w[k], ki[k], "debounced key bit");
    end
    else if (widx == 2)
    begin
      if (exp_addr == 0)
        check_value(w, {7'd0, adc_overload, merc_serial}, "control word 2, addr 0");
      else
        check_value(w, {4'd0, penny_alc}, "control word 2, addr 1");
    end
    else if (widx == 3)
    begin
      if (exp_addr == 0)
        check_value(w, {penny_serial, ozy_serial}, "control word 3, addr 0");
      else
        check_value(w, 16'd0, "control word 3, addr 1");
      exp_addr = (exp_addr == 1) ? 0 : 1;
    end
    else if (pos < n_sample)
    begin
      if (q_resync && (pos == 0))
      begin
        while ((wq.size() > 0) && !(sq[0] && (wq[0] == w)))
        begin
          void'(wq.pop_front());                     // sets lost with the clear
          void'(sq.pop_front());
        end
        q_resync = 1'b0;
      end
      if (wq.size() == 0)
      begin
        $display("Test failed");
        $fatal(1, "a sample word came out with no sample set left in the model");
      end
      check_value(w, wq.pop_front(), "sample word");
      void'(sq.pop_front());
    end
    else
      check_value(w, 16'd0, "pad word");
    widx++;
    if (widx == 256)
    begin
      widx = 0;
      frames_done++;
    end
  endtask

  always @(posedge IF_clk)
  begin
    logic [5:0] ki;
    if (IF_reset)
    begin
      wq.delete();
      sq.delete();
      kq.delete();
      {took, pend_chk, resync, addr_free, q_resync} = '0;
      beat_chan   = 0;
      widx        = 0;
      frames_done = 0;
      exp_addr    = 0;
    end
    else
    begin
      if (pend_chk)
        check_value(sample_ready, 0, "sample_ready high while a set is pending");
      pend_chk = 1'b0;
      if (sample_valid && sample_ready)              // accepted beat
      begin
        took = 1'b1;
        if (beat_chan == 0)
          mic_hold = sample_mic;
        wq.push_back(sample_iq[47:32]);
        sq.push_back(beat_chan == 0);
        wq.push_back(sample_iq[31:16]);
        sq.push_back(1'b0);
        wq.push_back(sample_iq[15:0]);
        sq.push_back(1'b0);
        if (beat_chan == lc)
        begin
          wq.push_back(mic_hold);
          sq.push_back(1'b0);
          beat_chan = 0;
          pend_chk  = 1'b1;
        end
        else
          beat_chan++;
      end
      check_value(out_valid, kq.size() != 0, "out_valid against words in the FIFO");
      if (out_valid && out_ready)
      begin
        ki = (kq.size() > 0) ? kq.pop_front() : 6'd0;
        check_word(out_data, ki);
      end
      if (UUT.fifo_clr)                              // FIFO emptied, resync
      begin
        kq.delete();
        resync   = 1'b1;
        q_resync = 1'b1;
        clr_count++;
      end
      for (int k = 0; k < 3; k++)
        ki[k+3] = (key_age[k] >= 20);
      ki[2:0] = keys;
      if (UUT.fifo_wreq)
        kq.push_back(ki);
      for (int k = 0; k < 3; k++)
        if (key_age[k] < 1000)
          key_age[k]++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // runs
  task automatic start_run(input int chan, input int mode);
    logic [31:0] r_ser;
    logic [31:0] r_alc;
    int          len;
    r_ser      = next_rand();                        // serials and alc of this run
    r_alc      = next_rand();
    ready_mode = mode;
    @(negedge IF_clk);
    IF_reset   = 1'b1;
    lc         = chan;
    last_chan  = 3'(chan);
    len        = 3 * (chan + 1) + 1;                 // words per loop
    n_sample   = (252 / len) * len;
    adc_overload = r_ser[31];
    merc_serial  = r_ser[23:16];
    penny_serial = r_ser[15:8];
    ozy_serial   = r_ser[7:0];
    penny_alc    = r_alc[27:16];
    repeat (2) @(negedge IF_clk);
    IF_reset = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    wait (frames_done >= n);
  endtask

  initial
  begin
    IF_reset     = 1'b1;
    sample_valid = 1'b0;
    sample_iq    = '0;
    sample_mic   = '0;
    last_chan    = '0;
    keys         = '0;
    adc_overload = 1'b0;
    merc_serial  = '0;
    penny_serial = '0;
    ozy_serial   = '0;
    penny_alc    = '0;
    out_ready    = 1'b0;
    ready_mode   = 0;
    lc           = 0;
    n_sample     = 0;
    clr_count    = 0;
    for (int k = 0; k < 3; k++)
    begin
      key_age[k]  = 0;
      key_hold[k] = 0;
    end
    start_run(0, 0);                                 // layout, one channel
    wait_frames(3);
    start_run(3, 1);
    wait_frames(3);
    start_run(7, 1);
    wait_frames(3);
    start_run(7, 2);                                 // hold out_ready low
    wait (clr_count != 0);
    ready_mode = 1;
    wait_frames(frames_done + 3);
    $display("Test passed");
    $finish;
  end

endmodule

/* sources.f */
common/tx_link_pkg.sv
source/key_debounce.sv
source/iq_mic_gather.sv
tx_frame/tx_word_fifo.sv
tx_frame/tx_frame_ctrl.sv
source/tx_link_top.sv
test/tb_tx_link.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_tx_link
RTL_TOP    := tx_link_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
